/* sources.f */
verilog/core_bus_pkg.sv
verilog/cache_bus_pkg.sv
verilog/dbus_to_cbus.sv
verilog/cbus_arbiter.sv
verilog/addr_translate.sv
verilog/mem_bridge_top.sv
verif/cbus_mem_model.sv
verif/mem_bridge_tb.sv

/* Bender.yml */
package:
  name: mem_bridge

sources:
  - files:
      - verilog/core_bus_pkg.sv
      - verilog/cache_bus_pkg.sv
      - verilog/dbus_to_cbus.sv
      - verilog/cbus_arbiter.sv
      - verilog/addr_translate.sv
      - verilog/mem_bridge_top.sv
  - target: simulation
    files:
      - verif/cbus_mem_model.sv
      - verif/mem_bridge_tb.sv

/* verif/mem_bridge_tb.sv */
`timescale 1ns/1ns

module mem_bridge_tb;

    // Ten directed transfers plus the random ones
    localparam int NUM_RAND_OPS = 40;
    localparam int NUM_OPS      = NUM_RAND_OPS + 10;
    localparam int CLK_HALF     = 20;

    logic                      clk;
    logic                      arst_n;
    core_bus_pkg::dbus_req_t   dreq     [core_bus_pkg::NUM_DPORTS-1:0];
    core_bus_pkg::dbus_resp_t  dresp    [core_bus_pkg::NUM_DPORTS-1:0];
    cache_bus_pkg::cbus_req_t  oreq;
    cache_bus_pkg::cbus_resp_t oresp;

    // Expected memory contents per physical word
    logic [31:0]               ref_mem  [0:255];
    // Outgoing request and time seen in each port's addr_ok cycle
    cache_bus_pkg::cbus_req_t  seen_req [core_bus_pkg::NUM_DPORTS-1:0];
    time                       ok_time  [core_bus_pkg::NUM_DPORTS-1:0];
    logic [15:0]               lfsr_q;

    mem_bridge_top uut (
        .clk    (clk),
        .arst_n (arst_n),
        .dreq   (dreq),
        .dresp  (dresp),
        .oreq   (oreq),
        .oresp  (oresp)
    );

    cbus_mem_model u_mem (
        .clk    (clk),
        .arst_n (arst_n),
        .oreq   (oreq),
        .oresp  (oresp)
    );

    always #CLK_HALF clk = ~clk;

    // ======================================================================
    // Reference rules and helpers
    // ======================================================================

    function automatic logic [31:0] fill_word(input int idx);
        return {16'hc0de, 8'(idx), ~8'(idx)};
    endfunction

    // kseg0 and kseg1 drop the top three bits and other segments pass
    function automatic logic [31:0] phys_addr(input logic [31:0] addr);
        if (addr[31:30] == 2'b10) begin
            return addr & 32'h1fff_ffff;
        end
        return addr;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strobe);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits   = {bits[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hb400) : (lfsr_q >> 1);
        end
        return bits;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    // ======================================================================
    // Core bus transfers
    // ======================================================================

    // Starts in the current cycle, returns in the data_ok cycle
    task automatic issue_op(input int p, input logic [31:0] addr,
                            input logic [3:0] strobe, input logic [31:0] data,
                            output logic [31:0] rdata);
        dreq[p].valid  = 1'b1;
        dreq[p].addr   = addr;
        dreq[p].size   = core_bus_pkg::MSIZE4;
        dreq[p].strobe = strobe;
        dreq[p].data   = data;
        while (!dresp[p].addr_ok) begin
            @(posedge clk);
            #2;
        end
        seen_req[p] = oreq;
        ok_time[p]  = $time;
        @(posedge clk);
        #2;
        dreq[p].valid = 1'b0;
        check_eq($sformatf("dresp[%0d].data_ok", p), dresp[p].data_ok, 1'b1);
        rdata = dresp[p].data;
    endtask

    task automatic port_write(input int p, input logic [31:0] addr,
                              input logic [3:0] strobe, input logic [31:0] data);
        logic [31:0] rdata;
        logic [31:0] pa;
        pa = phys_addr(addr);
        issue_op(p, addr, strobe, data, rdata);
        ref_mem[pa[9:2]] = merge_bytes(ref_mem[pa[9:2]], data, strobe);
    endtask

    task automatic port_read(input int p, input logic [31:0] addr);
        logic [31:0] rdata;
        logic [31:0] pa;
        pa = phys_addr(addr);
        issue_op(p, addr, 4'b0000, 32'h0, rdata);
        check_eq($sformatf("dresp[%0d].data", p), rdata, ref_mem[pa[9:2]]);
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================

    task automatic test_reset_state();
        check_eq("oreq.valid", oreq.valid, 1'b0);
        for (int i = 0; i < core_bus_pkg::NUM_DPORTS; i++) begin
            check_eq($sformatf("dresp[%0d].addr_ok", i), dresp[i].addr_ok, 1'b0);
            check_eq($sformatf("dresp[%0d].data_ok", i), dresp[i].data_ok, 1'b0);
        end
    endtask

    task automatic test_word_write_read();
        @(posedge clk);
        #2;
        port_write(0, 32'h8000_0010, 4'hf, 32'h1234_5678);
        check_eq("oreq.addr", seen_req[0].addr, 32'h0000_0010);
        check_eq("oreq.is_write", seen_req[0].is_write, 1'b1);
        check_eq("oreq.size", seen_req[0].size, core_bus_pkg::MSIZE4);
        check_eq("oreq.len", seen_req[0].len, cache_bus_pkg::MLEN1);
        port_read(0, 32'h8000_0010);
    endtask

    task automatic test_byte_strobe();
        @(posedge clk);
        #2;
        port_write(1, 32'ha000_0020, 4'hf, 32'haabb_ccdd);
        port_write(1, 32'ha000_0020, 4'b0101, 32'h1122_3344);
        port_read(1, 32'ha000_0020);
        check_eq("oreq.is_write", seen_req[1].is_write, 1'b0);
    endtask

    task automatic test_both_ports();
        @(posedge clk);
        #2;
        fork
            port_read(0, 32'h8000_0100);
            port_read(1, 32'h8000_0200);
        join
        check_eq("port 0 oreq.addr", seen_req[0].addr, 32'h0000_0100);
        check_eq("port 1 oreq.addr", seen_req[1].addr, 32'h0000_0200);
        check_eq("port 1 addr_ok after port 0", ok_time[1] > ok_time[0], 1'b1);
    endtask

    task automatic test_alias();
        @(posedge clk);
        #2;
        port_write(0, 32'h8000_0030, 4'hf, 32'hcafe_f00d);
        port_read(1, 32'ha000_0030);
        port_read(0, 32'h0000_0044);
        check_eq("oreq.addr", seen_req[0].addr, 32'h0000_0044);
    endtask

    // Operations follow each other right after addr_ok
    task automatic test_random();
        int          p;
        logic        wr;
        logic [3:0]  strobe;
        logic [31:0] data;
        logic [31:0] base;
        logic [31:0] addr;
        @(posedge clk);
        #2;
        for (int n = 0; n < NUM_RAND_OPS; n++) begin
            p      = int'(take_bits(1));
            wr     = 1'(take_bits(1));
            strobe = 4'(take_bits(4));
            data   = take_bits(32);
            case (take_bits(2))
                0: base = 32'h0000_0000;
                1: base = 32'h8000_0000;
                default: base = 32'ha000_0000;
            endcase
            addr = base | (take_bits(6) << 2);
            if (wr) begin
                port_write(p, addr, (strobe == 4'h0) ? 4'hf : strobe, data);
            end else begin
                port_read(p, addr);
            end
        end
    endtask

    // ======================================================================
    // Main sequence and watchdog
    // ======================================================================

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        lfsr_q = 16'd81;
        for (int i = 0; i < core_bus_pkg::NUM_DPORTS; i++) begin
            dreq[i]     = '0;
            seen_req[i] = '0;
            ok_time[i]  = 0;
        end
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = fill_word(i);
        end
        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;
        test_reset_state();
        test_word_write_read();
        test_byte_strobe();
        test_both_ports();
        test_alias();
        test_random();
        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin
        #((NUM_OPS * 20 + 200) * 2 * CLK_HALF);
        $display("Run timed out before all tests completed");
        $display("CHECKS FAILED");
        $fatal(1);
    end

endmodule

/* verif/cbus_mem_model.sv */
`timescale 1ns/1ns

module cbus_mem_model (
    input  logic                      clk,
    input  logic                      arst_n,
    input  cache_bus_pkg::cbus_req_t  oreq,
    output cache_bus_pkg::cbus_resp_t oresp
);

    logic [31:0] mem [0:255];
    logic [1:0]  wait_cnt;
    logic [7:0]  idx;

    // Word index from the physical address
    assign idx = oreq.addr[9:2];

    // Each word starts with a pattern built from its own index
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {16'hc0de, 8'(i), ~8'(i)};
        end
    end

    // Ready and last rise together two cycles after valid is seen
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            oresp    <= '0;
            wait_cnt <= '0;
        end else begin
            oresp <= '0;
            if (oreq.valid && !oresp.last) begin
                if (wait_cnt == 2'd1) begin
                    wait_cnt    <= '0;
                    oresp.ready <= 1'b1;
                    oresp.last  <= 1'b1;
                    oresp.data  <= mem[idx];
                    if (oreq.is_write) begin
                        for (int b = 0; b < 4; b++) begin
                            if (oreq.strobe[b]) begin
                                mem[idx][8*b +: 8] <= oreq.data[8*b +: 8];
                            end
                        end
                    end
                end else begin
                    wait_cnt <= wait_cnt + 2'd1;
                end
            end
        end
    end

endmodule

/* verilog/mem_bridge_top.sv */
`timescale 1ns/1ns

module mem_bridge_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  core_bus_pkg::dbus_req_t   dreq  [core_bus_pkg::NUM_DPORTS-1:0],
    output core_bus_pkg::dbus_resp_t  dresp [core_bus_pkg::NUM_DPORTS-1:0],
    output cache_bus_pkg::cbus_req_t  oreq,
    input  cache_bus_pkg::cbus_resp_t oresp
);

    // Per port cache bus requests and responses
    cache_bus_pkg::cbus_req_t  creq  [core_bus_pkg::NUM_DPORTS-1:0];
    cache_bus_pkg::cbus_resp_t cresp [core_bus_pkg::NUM_DPORTS-1:0];

    // Granted request, still with its virtual address
    cache_bus_pkg::cbus_req_t  areq;

    // ======================================================================
    // Port adapters
    // ======================================================================

    for (genvar i = 0; i < core_bus_pkg::NUM_DPORTS; i++) begin : g_port
        dbus_to_cbus u_adapter (
            .clk    (clk),
            .arst_n (arst_n),
            .dreq   (dreq[i]),
            .dresp  (dresp[i]),
            .creq   (creq[i]),
            .cresp  (cresp[i])
        );
    end

    // ======================================================================
    // Arbitration and translation
    // ======================================================================

    cbus_arbiter u_arbiter (
        .clk    (clk),
        .arst_n (arst_n),
        .creq   (creq),
        .cresp  (cresp),
        .areq   (areq),
        .oresp  (oresp)
    );

    addr_translate u_translate (
        .areq (areq),
        .oreq (oreq)
    );

endmodule

/* verilog/addr_translate.sv */
`timescale 1ns/1ns

module addr_translate (
    input  cache_bus_pkg::cbus_req_t areq,
    output cache_bus_pkg::cbus_req_t oreq
);

    cache_bus_pkg::addr_seg_t seg;

    // ======================================================================
    // Segment decode
    // ======================================================================

    // 0xx user space, 100 kseg0, 101 kseg1, 11x kseg2 and kseg3
    always_comb begin
        casez (areq.addr[31:29])
            3'b0??: seg = cache_bus_pkg::SEG_KUSEG;
            3'b100: seg = cache_bus_pkg::SEG_KSEG0;
            3'b101: seg = cache_bus_pkg::SEG_KSEG1;
            default: seg = cache_bus_pkg::SEG_KSEG23;
        endcase
    end

    // ======================================================================
    // Physical address
    // ======================================================================

    always_comb begin
        oreq = areq;
        // Both unmapped kernel windows alias the low 512 MB
        if (seg == cache_bus_pkg::SEG_KSEG0 || seg == cache_bus_pkg::SEG_KSEG1) begin
            oreq.addr = areq.addr & cache_bus_pkg::PHYS_MASK;
        end
    end

endmodule

/* verilog/cbus_arbiter.sv */
`timescale 1ns/1ns

module cbus_arbiter (
    input  logic                      clk,
    input  logic                      arst_n,
    input  cache_bus_pkg::cbus_req_t  creq  [core_bus_pkg::NUM_DPORTS-1:0],
    output cache_bus_pkg::cbus_resp_t cresp [core_bus_pkg::NUM_DPORTS-1:0],
    output cache_bus_pkg::cbus_req_t  areq,
    input  cache_bus_pkg::cbus_resp_t oresp
);

    typedef logic [$clog2(core_bus_pkg::NUM_DPORTS)-1:0] port_idx_t;

    cache_bus_pkg::arb_state_t state_q;
    cache_bus_pkg::arb_state_t state_d;
    port_idx_t                 grant_q;
    port_idx_t                 sel_idx;
    logic                      any_valid;
    logic                      beat_done;
    cache_bus_pkg::cbus_req_t  buf_q;

    assign beat_done = oresp.ready && oresp.last;

    // ======================================================================
    // Fixed priority select
    // ======================================================================

    // Scan from the top so the lowest valid index wins
    always_comb begin
        any_valid = 1'b0;
        sel_idx   = '0;
        for (int i = core_bus_pkg::NUM_DPORTS - 1; i >= 0; i--) begin
            if (creq[i].valid) begin
                any_valid = 1'b1;
                sel_idx   = port_idx_t'(i);
            end
        end
    end

    // ======================================================================
    // Grant FSM
    // ======================================================================

    always_comb begin
        state_d = state_q;
        case (state_q)
            cache_bus_pkg::ARB_IDLE: begin
                if (any_valid) begin
                    state_d = cache_bus_pkg::ARB_HOLD;
                end
            end
            default: begin
                if (beat_done) begin
                    state_d = cache_bus_pkg::ARB_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= cache_bus_pkg::ARB_IDLE;
            grant_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == cache_bus_pkg::ARB_IDLE && any_valid) begin
                grant_q <= sel_idx;
            end
        end
    end

    // Granted request is captured on the grant edge
    always_ff @(posedge clk) begin
        if (state_q == cache_bus_pkg::ARB_IDLE && any_valid) begin
            buf_q <= creq[sel_idx];
        end
    end

    // Outgoing request is valid only while the grant is held
    always_comb begin
        areq       = buf_q;
        areq.valid = (state_q == cache_bus_pkg::ARB_HOLD);
    end

    // ======================================================================
    // Response steering
    // ======================================================================

    always_comb begin
        for (int i = 0; i < core_bus_pkg::NUM_DPORTS; i++) begin
            cresp[i] = '0;
            if (state_q == cache_bus_pkg::ARB_HOLD && grant_q == port_idx_t'(i)) begin
                cresp[i] = oresp;
            end
        end
    end

endmodule

/* verilog/dbus_to_cbus.sv */
`timescale 1ns/1ns

module dbus_to_cbus (
    input  logic                     clk,
    input  logic                     arst_n,
    input  core_bus_pkg::dbus_req_t  dreq,
    output core_bus_pkg::dbus_resp_t dresp,
    output cache_bus_pkg::cbus_req_t creq,
    input  cache_bus_pkg::cbus_resp_t cresp
);

    cache_bus_pkg::adp_state_t state_q;
    cache_bus_pkg::adp_state_t state_d;
    logic                      beat_done;
    logic                      data_ok_q;
    core_bus_pkg::word_t       data_q;

    // Single beat finishes when the memory shows ready and last together
    assign beat_done = cresp.ready && cresp.last;

    // ======================================================================
    // Request conversion
    // ======================================================================

    always_comb begin
        // Released for one cycle after completion so the arbiter
        // does not grant the same request twice
        creq.valid    = dreq.valid && (state_q != cache_bus_pkg::ADP_DONE);
        creq.is_write = |dreq.strobe;
        creq.size     = dreq.size;
        creq.addr     = dreq.addr;
        creq.strobe   = dreq.strobe;
        creq.data     = dreq.data;
        creq.len      = cache_bus_pkg::MLEN1;
    end

    // ======================================================================
    // Adapter FSM
    // ======================================================================

    always_comb begin
        state_d = state_q;
        case (state_q)
            cache_bus_pkg::ADP_IDLE: begin
                if (beat_done) begin
                    state_d = cache_bus_pkg::ADP_DONE;
                end else if (dreq.valid) begin
                    state_d = cache_bus_pkg::ADP_WAIT;
                end
            end
            cache_bus_pkg::ADP_WAIT: begin
                if (beat_done) begin
                    state_d = cache_bus_pkg::ADP_DONE;
                end
            end
            default: begin
                state_d = cache_bus_pkg::ADP_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= cache_bus_pkg::ADP_IDLE;
            data_ok_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            data_ok_q <= beat_done;
        end
    end

    // Read data is presented with data_ok one cycle after the beat
    always_ff @(posedge clk) begin
        if (beat_done) begin
            data_q <= cresp.data;
        end
    end

    assign dresp.addr_ok = beat_done;
    assign dresp.data_ok = data_ok_q;
    assign dresp.data    = data_q;

endmodule

/* verilog/cache_bus_pkg.sv */
package cache_bus_pkg;

    // ======================================================================
    // Cache bus
    // ======================================================================

    // Burst length, encoded as beats minus one
    typedef enum logic [3:0] {
        MLEN1 = 4'b0000,
        MLEN2 = 4'b0001,
        MLEN4 = 4'b0011,
        MLEN8 = 4'b0111
    } mlen_t;

    // Requester holds every field until ready and last
    typedef struct packed {
        logic                 valid;
        logic                 is_write;
        core_bus_pkg::msize_t  size;
        core_bus_pkg::word_t   addr;
        core_bus_pkg::strobe_t strobe;
        core_bus_pkg::word_t   data;
        mlen_t                len;
    } cbus_req_t;

    typedef struct packed {
        logic                ready;
        logic                last;
        core_bus_pkg::word_t data;
    } cbus_resp_t;

    // ======================================================================
    // Address segments
    // ======================================================================

    // Selected by the top three virtual address bits
    typedef enum logic [1:0] {
        SEG_KUSEG  = 2'b00,
        SEG_KSEG0  = 2'b01,
        SEG_KSEG1  = 2'b10,
        SEG_KSEG23 = 2'b11
    } addr_seg_t;

    // Clears the segment bits of an unmapped kernel address
    localparam logic [31:0] PHYS_MASK = 32'h1fff_ffff;

    // ======================================================================
    // Controller states
    // ======================================================================

    typedef enum logic {
        ARB_IDLE,
        ARB_HOLD
    } arb_state_t;

    typedef enum logic [1:0] {
        ADP_IDLE,
        ADP_WAIT,
        ADP_DONE
    } adp_state_t;

endpackage

/* verilog/core_bus_pkg.sv */
package core_bus_pkg;

    // ======================================================================
    // Shared word types
    // ======================================================================

    // Data or address word
    typedef logic [31:0] word_t;

    // One enable bit per byte lane
    typedef logic [3:0] strobe_t;

    // Access size in bytes
    typedef enum logic [2:0] {
        MSIZE1 = 3'b000,
        MSIZE2 = 3'b001,
        MSIZE4 = 3'b010
    } msize_t;

    // Number of data ports on the core side
    localparam int NUM_DPORTS = 2;

    // ======================================================================
    // Core data bus
    // ======================================================================

    // Request is held with stable fields until addr_ok
    typedef struct packed {
        logic    valid;
        word_t   addr;
        msize_t  size;
        strobe_t strobe;
        word_t   data;
    } dbus_req_t;

    // addr_ok accepts the request, data_ok pulses once with read data
    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t data;
    } dbus_resp_t;

endpackage
